// File: source/eth_stream_pkg.sv
// Stream beat, FIFO status and write-side state types shared by the frame buffer RTL
`default_nettype none

package eth_stream_pkg;

    // Stream data path widths
    parameter int DATA_WIDTH = 64;
    parameter int KEEP_WIDTH = DATA_WIDTH / 8;

    // One beat of a frame
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
    } stream_word_t;

    // One-cycle status pulses of a frame FIFO
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

    // Write side of the frame FIFO
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FRAME,
        WR_DROP
    } wr_state_t;

endpackage

`default_nettype wire

// File: source/ptp_pkg.sv
// PTP timestamp layout used by the receive timestamp path and the top level
`default_nettype none

package ptp_pkg;

    // Field widths of the 96-bit time format
    parameter int PTP_SEC_WIDTH = 48;
    parameter int PTP_NS_WIDTH  = 32;
    parameter int PTP_FNS_WIDTH = 16;
    parameter int PTP_TS_WIDTH  = PTP_SEC_WIDTH + PTP_NS_WIDTH + PTP_FNS_WIDTH;

    // Seconds, nanoseconds and fractional nanoseconds
    typedef struct packed {
        logic [PTP_SEC_WIDTH-1:0] seconds;
        logic [PTP_NS_WIDTH-1:0]  ns;
        logic [PTP_FNS_WIDTH-1:0] fns;
    } ptp_ts_t;

endpackage

`default_nettype wire

// File: source/frame_fifo.sv
// Store-and-forward frame FIFO that drops bad or overflowing frames and pulses status
`timescale 1ns/1ps
`default_nettype none

module frame_fifo
    import eth_stream_pkg::*;
#(
    parameter int DEPTH_WORDS    = 64,
    parameter int USER_WIDTH     = 1,
    parameter bit DROP_WHEN_FULL = 0
) (
    input  logic                  logic_clk,
    input  logic                  logic_rst,
    input  stream_word_t          in_word,
    input  logic [USER_WIDTH-1:0] in_user,
    input  logic                  in_valid,
    output logic                  in_ready,
    output stream_word_t          out_word,
    output logic [USER_WIDTH-1:0] out_user,
    output logic                  out_valid,
    input  logic                  out_ready,
    output fifo_status_t          status
);

    localparam int ADDR_WIDTH = $clog2(DEPTH_WORDS);
    localparam int PTR_WIDTH  = ADDR_WIDTH + 1;
    localparam logic [PTR_WIDTH-1:0] DEPTH_PTR = PTR_WIDTH'(DEPTH_WORDS);

    stream_word_t          word_mem [DEPTH_WORDS];
    logic [USER_WIDTH-1:0] user_mem [DEPTH_WORDS];

    // Extra pointer bit tells full from empty
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr_next;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] wr_ptr_next;
    logic [PTR_WIDTH-1:0] wr_commit;
    logic [PTR_WIDTH-1:0] wr_commit_next;
    logic [PTR_WIDTH-1:0] fill;
    logic [PTR_WIDTH-1:0] fill_next;

    wr_state_t    wr_state;
    wr_state_t    wr_state_next;
    fifo_status_t status_next;

    logic in_fire;
    logic full;
    logic mem_we;
    logic rd_load;
    logic in_ready_next;

    assign in_fire = in_valid && in_ready;

    // Fill counts speculative words too, so a long frame can find the buffer full
    assign fill = wr_ptr - rd_ptr;
    assign full = (fill == DEPTH_PTR);

    // Only committed frames are visible to the reader
    assign rd_load     = (rd_ptr != wr_commit) && (!out_valid || out_ready);
    assign rd_ptr_next = rd_load ? rd_ptr + 1'b1 : rd_ptr;

    always_comb begin
        wr_state_next  = wr_state;
        wr_ptr_next    = wr_ptr;
        wr_commit_next = wr_commit;
        status_next    = '0;
        mem_we         = 1'b0;
        if (in_fire) begin
            if (wr_state == WR_DROP) begin
                // Swallow the rest of an overflowed frame
                if (in_word.last) begin
                    wr_state_next = WR_IDLE;
                end
            end else if (full) begin
                wr_ptr_next          = wr_commit;
                status_next.overflow = 1'b1;
                wr_state_next        = in_word.last ? WR_IDLE : WR_DROP;
            end else begin
                mem_we      = 1'b1;
                wr_ptr_next = wr_ptr + 1'b1;
                if (in_word.last) begin
                    wr_state_next = WR_IDLE;
                    // Bad bit only counts on the last beat
                    if (in_user[0]) begin
                        wr_ptr_next           = wr_commit;
                        status_next.bad_frame = 1'b1;
                    end else begin
                        wr_commit_next         = wr_ptr + 1'b1;
                        status_next.good_frame = 1'b1;
                    end
                end else begin
                    wr_state_next = WR_FRAME;
                end
            end
        end
    end

    // Ready for the next cycle, from the pointers after this edge
    assign fill_next     = wr_ptr_next - rd_ptr_next;
    assign in_ready_next = DROP_WHEN_FULL ? 1'b1 : (fill_next != DEPTH_PTR);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_state  <= WR_IDLE;
            wr_ptr    <= '0;
            wr_commit <= '0;
            rd_ptr    <= '0;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
            status    <= '0;
        end else begin
            wr_state  <= wr_state_next;
            wr_ptr    <= wr_ptr_next;
            wr_commit <= wr_commit_next;
            rd_ptr    <= rd_ptr_next;
            in_ready  <= in_ready_next;
            status    <= status_next;
            if (rd_load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    // Storage and output register
    always_ff @(posedge logic_clk) begin
        if (mem_we) begin
            word_mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_word;
            user_mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_user;
        end
        if (rd_load) begin
            out_word <= word_mem[rd_ptr[ADDR_WIDTH-1:0]];
            out_user <= user_mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // Registered ready has to track the pointers of the previous edge
    a_no_push_full: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (!DROP_WHEN_FULL && in_fire) |-> !full
    ) else $error("frame_fifo accepted a beat while full");

    a_status_onehot: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        $onehot0(status)
    ) else $error("frame_fifo status pulses overlap");

    a_out_stable: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word))
    ) else $error("frame_fifo output changed under back-pressure");

endmodule

`default_nettype wire

// File: source/rx_ptp_ts_path.sv
// Stamps receive frames with PTP time on entry and queues the time as each frame leaves
`timescale 1ns/1ps
`default_nettype none

module rx_ptp_ts_path
    import ptp_pkg::*;
#(
    parameter int TS_DEPTH = 8
) (
    input  logic    logic_clk,
    input  logic    logic_rst,
    input  ptp_ts_t ptp_ts,
    input  logic    mac_valid,
    input  logic    mac_last,
    output ptp_ts_t stamp_ts,
    input  logic    fifo_out_valid,
    input  logic    fifo_out_ready,
    input  logic    fifo_out_last,
    input  ptp_ts_t fifo_out_ts,
    output ptp_ts_t ts,
    output logic    ts_valid,
    input  logic    ts_ready
);

    localparam int TS_ADDR_WIDTH = $clog2(TS_DEPTH);
    localparam int TS_PTR_WIDTH  = TS_ADDR_WIDTH + 1;

    // Input side
    logic    in_frame;
    logic    mac_first;
    ptp_ts_t held_ts;

    // Output side
    logic out_frame;
    logic out_fire;
    logic out_first;

    // Timestamp queue
    ptp_ts_t                 ts_mem [TS_DEPTH];
    logic [TS_PTR_WIDTH-1:0] ts_wr_ptr;
    logic [TS_PTR_WIDTH-1:0] ts_rd_ptr;
    logic                    ts_full;
    logic                    ts_push;
    logic                    ts_pop;

    // First beat takes the live time, later beats repeat it
    assign mac_first = mac_valid && !in_frame;
    assign stamp_ts  = mac_first ? ptp_ts : held_ts;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_frame <= 1'b0;
        end else if (mac_valid) begin
            in_frame <= !mac_last;
        end
    end

    always_ff @(posedge logic_clk) begin
        if (mac_first) begin
            held_ts <= ptp_ts;
        end
    end

    assign out_fire  = fifo_out_valid && fifo_out_ready;
    assign out_first = out_fire && !out_frame;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            out_frame <= 1'b0;
        end else if (out_fire) begin
            out_frame <= !fifo_out_last;
        end
    end

    // Full when the pointers differ only in the wrap bit
    assign ts_full  = (ts_wr_ptr == {~ts_rd_ptr[TS_ADDR_WIDTH], ts_rd_ptr[TS_ADDR_WIDTH-1:0]});
    assign ts_valid = (ts_wr_ptr != ts_rd_ptr);
    assign ts       = ts_mem[ts_rd_ptr[TS_ADDR_WIDTH-1:0]];
    // A full queue loses the time but not the frame
    assign ts_push  = out_first && !ts_full;
    assign ts_pop   = ts_valid && ts_ready;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            ts_wr_ptr <= '0;
            ts_rd_ptr <= '0;
        end else begin
            if (ts_push) begin
                ts_wr_ptr <= ts_wr_ptr + 1'b1;
            end
            if (ts_pop) begin
                ts_rd_ptr <= ts_rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (ts_push) begin
            ts_mem[ts_wr_ptr[TS_ADDR_WIDTH-1:0]] <= fifo_out_ts;
        end
    end

    // Queue never holds more than TS_DEPTH entries
    a_ts_no_overrun: assert property (
        @(posedge logic_clk) disable iff (logic_rst)
        TS_PTR_WIDTH'(ts_wr_ptr - ts_rd_ptr) <= TS_PTR_WIDTH'(TS_DEPTH)
    ) else $error("timestamp pushed into a full queue");

endmodule

`default_nettype wire

// File: source/eth_frame_buffer.sv
// Top level of the frame buffer shell, joining both frame FIFOs and the receive timestamp path
`timescale 1ns/1ps
`default_nettype none

module eth_frame_buffer
    import eth_stream_pkg::*;
    import ptp_pkg::*;
#(
    parameter int TX_DEPTH_WORDS = 64,
    parameter int RX_DEPTH_WORDS = 32,
    parameter int TS_DEPTH       = 8
) (
    input  logic         logic_clk,
    input  logic         logic_rst,

    // Transmit from the user
    input  stream_word_t tx_in,
    input  logic         tx_in_bad,
    input  logic         tx_in_valid,
    output logic         tx_in_ready,

    // Transmit toward the MAC
    output stream_word_t tx_out,
    output logic         tx_out_valid,
    input  logic         tx_out_ready,

    // Receive from the MAC, no back-pressure
    input  stream_word_t rx_in,
    input  logic         rx_in_bad,
    input  logic         rx_in_valid,

    // Receive toward the user
    output stream_word_t rx_out,
    output logic         rx_out_valid,
    input  logic         rx_out_ready,

    // Timestamps
    input  ptp_ts_t      ptp_ts,
    output ptp_ts_t      rx_ts,
    output logic         rx_ts_valid,
    input  logic         rx_ts_ready,

    output fifo_status_t tx_status,
    output fifo_status_t rx_status
);

    localparam int TX_USER_WIDTH = 1;
    // Bad bit at bit 0, timestamp above it
    localparam int RX_USER_WIDTH = PTP_TS_WIDTH + 1;

    ptp_ts_t                  rx_stamp_ts;
    logic [RX_USER_WIDTH-1:0] rx_out_user;

    frame_fifo #(
        .DEPTH_WORDS   (TX_DEPTH_WORDS),
        .USER_WIDTH    (TX_USER_WIDTH),
        .DROP_WHEN_FULL(1'b0)
    ) tx_fifo (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .in_word  (tx_in),
        .in_user  (tx_in_bad),
        .in_valid (tx_in_valid),
        .in_ready (tx_in_ready),
        .out_word (tx_out),
        .out_user (),
        .out_valid(tx_out_valid),
        .out_ready(tx_out_ready),
        .status   (tx_status)
    );

    frame_fifo #(
        .DEPTH_WORDS   (RX_DEPTH_WORDS),
        .USER_WIDTH    (RX_USER_WIDTH),
        .DROP_WHEN_FULL(1'b1)
    ) rx_fifo (
        .logic_clk(logic_clk),
        .logic_rst(logic_rst),
        .in_word  (rx_in),
        .in_user  ({rx_stamp_ts, rx_in_bad}),
        .in_valid (rx_in_valid),
        .in_ready (),
        .out_word (rx_out),
        .out_user (rx_out_user),
        .out_valid(rx_out_valid),
        .out_ready(rx_out_ready),
        .status   (rx_status)
    );

    rx_ptp_ts_path #(
        .TS_DEPTH(TS_DEPTH)
    ) rx_ts_path (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .ptp_ts        (ptp_ts),
        .mac_valid     (rx_in_valid),
        .mac_last      (rx_in.last),
        .stamp_ts      (rx_stamp_ts),
        .fifo_out_valid(rx_out_valid),
        .fifo_out_ready(rx_out_ready),
        .fifo_out_last (rx_out.last),
        .fifo_out_ts   (rx_out_user[RX_USER_WIDTH-1:1]),
        .ts            (rx_ts),
        .ts_valid      (rx_ts_valid),
        .ts_ready      (rx_ts_ready)
    );

endmodule

`default_nettype wire

// File: test/tb_eth_frame_buffer.sv
// Directed testbench for the frame buffer shell, compiled from build.f and run by the Makefile
`timescale 1ns/1ps
`default_nettype none

module tb_eth_frame_buffer
    import eth_stream_pkg::*;
    import ptp_pkg::*;
();

    localparam int TIMEOUT = 2000;

    logic         logic_clk = 1'b0;
    logic         logic_rst;
    stream_word_t tx_in, tx_out, rx_in, rx_out;
    logic         tx_in_bad, tx_in_valid, tx_in_ready, tx_out_valid;
    logic         tx_out_ready = 1'b0;
    logic         rx_in_bad, rx_in_valid, rx_out_valid, rx_out_ready;
    logic         rx_ts_valid, rx_ts_ready;
    ptp_ts_t      ptp_ts = '{seconds: 48'h1234, ns: 32'd0, fns: 16'd0};
    ptp_ts_t      rx_ts;
    fifo_status_t tx_status, rx_status;

    // Scoreboard, filled by the drivers and by the output monitor
    stream_word_t exp_tx[$], got_tx[$], exp_rx[$], got_rx[$];
    ptp_ts_t      exp_ts[$], got_ts[$];
    int tx_done = 0, rx_done = 0, ts_done = 0;
    int tx_good = 0, tx_bad = 0, tx_stall = 0, rx_good = 0, rx_bad = 0, rx_ovf = 0;
    int tx_ovf = 0;
    int error_cnt = 0, check_cnt = 0;
    logic [31:0] data_lfsr = 32'h7099;
    logic [31:0] ready_lfsr = 32'h7099;
    logic        ready_bit;
    logic        random_tx_ready = 1'b0;

    eth_frame_buffer i_eth_frame_buffer (.*);

    always #10 logic_clk = ~logic_clk;

    // PTP time advances once per cycle
    always @(posedge logic_clk) begin
        #2;
        ptp_ts.ns = ptp_ts.ns + 32'd1;
        ptp_ts.fns = ptp_ts.fns + 16'h0101;
    end

    // Random mode lets a word out about one cycle in four
    always @(posedge logic_clk) begin
        #2;
        if (random_tx_ready) begin
            ready_lfsr = lfsr_next(ready_lfsr);
            ready_bit = ready_lfsr[0];
            ready_lfsr = lfsr_next(ready_lfsr);
            tx_out_ready = ready_bit && ready_lfsr[0];
        end else begin
            tx_out_ready = 1'b1;
        end
    end

    // Inputs are stable at the falling edge, so a beat seen here transfers on the next rise
    always @(negedge logic_clk) begin
        if (!logic_rst) begin
            if (tx_out_valid && tx_out_ready) begin
                got_tx.push_back(tx_out);
            end
            if (rx_out_valid && rx_out_ready) begin
                got_rx.push_back(rx_out);
            end
            if (rx_ts_valid && rx_ts_ready) begin
                got_ts.push_back(rx_ts);
            end
            tx_good += int'(tx_status.good_frame);
            tx_bad += int'(tx_status.bad_frame);
            tx_ovf += int'(tx_status.overflow);
            tx_stall += int'(tx_in_valid && !tx_in_ready);
            rx_good += int'(rx_status.good_frame);
            rx_bad += int'(rx_status.bad_frame);
            rx_ovf += int'(rx_status.overflow);
        end
    end

    // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            data_lfsr = lfsr_next(data_lfsr);
            v = {v[62:0], data_lfsr[0]};
        end
    endtask

    task automatic make_word(input logic last, output stream_word_t w);
        logic [63:0] bits;
        draw_bits(64, bits);
        w.data = bits;
        w.keep = 8'hFF;
        w.last = last;
        if (last) begin
            // Short tail beat
            draw_bits(3, bits);
            w.keep = 8'hFF >> bits[2:0];
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        check_cnt++;
        assert (actual == expected) else begin
            error_cnt++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_timeout(input string name, input int waited, input string what);
        assert (waited < TIMEOUT) else begin
            error_cnt++;
            $display("%s: timed out waiting for %s", name, what);
        end
    endtask

    task automatic send_tx_frame(input int len, input logic bad, input string name);
        stream_word_t frame[$];
        stream_word_t w;
        int n;
        for (int i = 0; i < len; i++) begin
            make_word(i == len - 1, w);
            tx_in = w;
            tx_in_bad = bad && (i == len - 1);
            tx_in_valid = 1'b1;
            n = 0;
            @(negedge logic_clk);
            while (!tx_in_ready && n < TIMEOUT) begin
                @(negedge logic_clk);
                n++;
            end
            check_timeout(name, n, "tx_in_ready");
            @(posedge logic_clk);
            #2;
            frame.push_back(w);
        end
        tx_in_valid = 1'b0;
        tx_in_bad = 1'b0;
        if (!bad) begin
            foreach (frame[i]) exp_tx.push_back(frame[i]);
        end
    endtask

    // No ready on this side, so one beat goes in every cycle
    task automatic send_rx_frame(input int len, input logic bad, input logic expect_out);
        stream_word_t w;
        ptp_ts_t stamp;
        for (int i = 0; i < len; i++) begin
            make_word(i == len - 1, w);
            rx_in = w;
            rx_in_bad = bad && (i == len - 1);
            rx_in_valid = 1'b1;
            @(negedge logic_clk);
            if (i == 0) begin
                stamp = ptp_ts;
            end
            @(posedge logic_clk);
            #2;
            if (expect_out) begin
                exp_rx.push_back(w);
            end
        end
        rx_in_valid = 1'b0;
        rx_in_bad = 1'b0;
        if (expect_out) begin
            exp_ts.push_back(stamp);
        end
    endtask

    task automatic compare_tx(input string name);
        int n;
        n = 0;
        while (got_tx.size() < exp_tx.size() && n < TIMEOUT) begin
            @(posedge logic_clk);
            #2;
            n++;
        end
        check_timeout(name, n, "transmit output");
        for (int i = tx_done; i < exp_tx.size() && i < got_tx.size(); i++) begin
            check_value(name, 128'(exp_tx[i]), 128'(got_tx[i]));
        end
        tx_done = exp_tx.size();
    endtask

    task automatic compare_rx(input string name);
        int n;
        n = 0;
        while ((got_rx.size() < exp_rx.size() || got_ts.size() < exp_ts.size())
               && n < TIMEOUT) begin
            @(posedge logic_clk);
            #2;
            n++;
        end
        check_timeout(name, n, "receive output and timestamps");
        for (int i = rx_done; i < exp_rx.size() && i < got_rx.size(); i++) begin
            check_value({name, " word"}, 128'(exp_rx[i]), 128'(got_rx[i]));
        end
        for (int i = ts_done; i < exp_ts.size() && i < got_ts.size(); i++) begin
            check_value({name, " timestamp"}, 128'(exp_ts[i]), 128'(got_ts[i]));
        end
        rx_done = exp_rx.size();
        ts_done = exp_ts.size();
    endtask

    task automatic test_tx_lengths();
        int g0;
        g0 = tx_good;
        send_tx_frame(1, 1'b0, "tx_lengths");
        send_tx_frame(2, 1'b0, "tx_lengths");
        send_tx_frame(7, 1'b0, "tx_lengths");
        send_tx_frame(20, 1'b0, "tx_lengths");
        compare_tx("tx_lengths");
        check_value("tx_lengths good_frame", 128'(4), 128'(tx_good - g0));
    endtask

    task automatic test_tx_bad();
        int g0;
        int b0;
        g0 = tx_good;
        b0 = tx_bad;
        send_tx_frame(3, 1'b0, "tx_bad");
        send_tx_frame(5, 1'b1, "tx_bad");
        send_tx_frame(2, 1'b0, "tx_bad");
        compare_tx("tx_bad");
        check_value("tx_bad good_frame", 128'(2), 128'(tx_good - g0));
        check_value("tx_bad bad_frame", 128'(1), 128'(tx_bad - b0));
    endtask

    // 130 words in total against a 64-word FIFO
    task automatic test_tx_backpressure();
        int s0;
        int o0;
        s0 = tx_stall;
        o0 = tx_ovf;
        @(negedge logic_clk);
        random_tx_ready = 1'b1;
        @(posedge logic_clk);
        #2;
        send_tx_frame(20, 1'b0, "tx_backpressure");
        send_tx_frame(30, 1'b0, "tx_backpressure");
        send_tx_frame(25, 1'b0, "tx_backpressure");
        send_tx_frame(40, 1'b0, "tx_backpressure");
        send_tx_frame(15, 1'b0, "tx_backpressure");
        compare_tx("tx_backpressure");
        @(negedge logic_clk);
        random_tx_ready = 1'b0;
        @(posedge logic_clk);
        #2;
        check_cnt++;
        assert (tx_stall > s0) else begin
            error_cnt++;
            $display("tx_backpressure: tx_in_ready never went low while the output was stalled");
        end
        // Transmit side waits for space and never drops
        check_value("tx_backpressure overflow", 128'(0), 128'(tx_ovf - o0));
    endtask

    task automatic test_rx_timestamps();
        int g0;
        g0 = rx_good;
        send_rx_frame(2, 1'b0, 1'b1);
        send_rx_frame(6, 1'b0, 1'b1);
        send_rx_frame(1, 1'b0, 1'b1);
        send_rx_frame(9, 1'b0, 1'b1);
        compare_rx("rx_timestamps");
        check_value("rx_timestamps good_frame", 128'(4), 128'(rx_good - g0));
    endtask

    // Stalled reader: 12 stored, bad 8 dropped, 16 stored, 10 overflows, 4 still fits
    task automatic test_rx_overflow();
        int g0;
        int b0;
        int o0;
        g0 = rx_good;
        b0 = rx_bad;
        o0 = rx_ovf;
        rx_out_ready = 1'b0;
        send_rx_frame(12, 1'b0, 1'b1);
        send_rx_frame(8, 1'b1, 1'b0);
        send_rx_frame(16, 1'b0, 1'b1);
        send_rx_frame(10, 1'b0, 1'b0);
        send_rx_frame(4, 1'b0, 1'b1);
        rx_out_ready = 1'b1;
        compare_rx("rx_overflow");
        check_value("rx_overflow good_frame", 128'(3), 128'(rx_good - g0));
        check_value("rx_overflow bad_frame", 128'(1), 128'(rx_bad - b0));
        check_value("rx_overflow overflow", 128'(1), 128'(rx_ovf - o0));
    endtask

    task automatic finish_run(input logic timed_out);
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0 && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    initial begin
        logic_rst = 1'b1;
        tx_in = '0;
        tx_in_bad = 1'b0;
        tx_in_valid = 1'b0;
        rx_in = '0;
        rx_in_bad = 1'b0;
        rx_in_valid = 1'b0;
        rx_out_ready = 1'b0;
        rx_ts_ready = 1'b0;
        repeat (15) @(posedge logic_clk);
        @(negedge logic_clk);
        check_value("reset outputs", 128'(0), 128'({tx_in_ready, tx_out_valid, rx_out_valid,
                                                   rx_ts_valid, tx_status, rx_status}));
        @(posedge logic_clk);
        #2;
        logic_rst = 1'b0;
        @(posedge logic_clk);
        @(negedge logic_clk);
        check_value("tx_in_ready after reset", 128'(1), 128'(tx_in_ready));
        @(posedge logic_clk);
        #2;
        rx_out_ready = 1'b1;
        rx_ts_ready = 1'b1;
        test_tx_lengths();
        test_tx_bad();
        test_tx_backpressure();
        test_rx_timestamps();
        test_rx_overflow();
        check_value("transmit word count", 128'(exp_tx.size()), 128'(got_tx.size()));
        check_value("receive word count", 128'(exp_rx.size()), 128'(got_rx.size()));
        check_value("timestamp count", 128'(exp_ts.size()), 128'(got_ts.size()));
        finish_run(1'b0);
    end

    // Hard limit on the whole run
    initial begin
        #(20 * 20000);
        $display("Simulation time limit reached before the tests finished");
        finish_run(1'b1);
    end

endmodule

`default_nettype wire

// File: build.f
source/eth_stream_pkg.sv
source/ptp_pkg.sv
source/frame_fifo.sv
source/rx_ptp_ts_path.sv
source/eth_frame_buffer.sv
test/tb_eth_frame_buffer.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := tb_eth_frame_buffer
FILELIST := build.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
